/* Makefile */
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module tb_gnn_accum -f sources.f

sim:
	verilator --binary --timing --assert --top-module tb_gnn_accum -Mdir obj_dir -f sources.f
	out=$$(./obj_dir/Vtb_gnn_accum); echo "$$out"; echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

/* hw/bank_dispatch.sv */
`timescale 1ns/1ps

module bank_dispatch import gnn_feature_pkg::*, gnn_bank_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_sos,
    input  logic                     in_eos,
    input  logic                     in_change,
    input  logic [feature_width-1:0] in_data,
    input  logic [node_id_width-1:0] in_node_id,
    input  logic [num_banks-1:0]     bank_busy,
    vertex_stream_if.source          bank_stream [num_banks],
    output logic                     in_ready
);

    logic [bank_idx_width-1:0] pick_idx;
    logic [bank_idx_width-1:0] sel_q;
    logic [bank_idx_width-1:0] cur_sel;
    logic                      fwd_active;
    logic [num_banks-1:0]      hit_vec;

    // lowest idle bank wins
    always_comb begin
        pick_idx = '0;
        for (int i = num_banks - 1; i >= 0; i--) begin
            if (!bank_busy[i]) begin
                pick_idx = bank_idx_width'(i);
            end
        end
    end

    assign cur_sel = in_sos ? pick_idx : sel_q;

    always_comb begin
        hit_vec = '0;
        if (in_sos || fwd_active) begin
            hit_vec[cur_sel] = 1'b1;
        end
    end

    for (genvar i = 0; i < num_banks; i++) begin : gen_route
        assign bank_stream[i].data    = hit_vec[i] ? in_data : '0;
        assign bank_stream[i].node_id = in_node_id;
        assign bank_stream[i].sos     = in_sos && hit_vec[i];
        assign bank_stream[i].eos     = in_eos && hit_vec[i];
        assign bank_stream[i].change  = in_change && hit_vec[i];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fwd_active <= 1'b0;
            sel_q      <= '0;
        end else if (in_sos && !in_eos) begin
            fwd_active <= 1'b1;
            sel_q      <= pick_idx;
        end else if (fwd_active && in_eos) begin
            fwd_active <= 1'b0;
        end
    end

    assign in_ready = (|(~bank_busy)) && !fwd_active;

endmodule

/* hw/gnn_accum_top.sv */
`timescale 1ns/1ps

module gnn_accum_top import gnn_feature_pkg::*, gnn_bank_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_sos,
    input  logic                      in_eos,
    input  logic                      in_change,
    input  logic [feature_width-1:0]  in_data,
    input  logic [node_id_width-1:0]  in_node_id,
    output logic                      in_ready,
    input  logic                      rd_en,
    input  logic [node_id_width-1:0]  rd_node,
    input  logic [word_idx_width-1:0] rd_word,
    output logic [word_width-1:0]     rd_data
);

    vertex_stream_if bank_stream [num_banks] ();
    out_req_if       bank_out    [num_banks] ();

    logic [num_banks-1:0]     bank_busy;
    logic                     wr_en;
    logic                     wr_sos;
    logic [node_id_width-1:0] wr_node_id;
    logic [word_width-1:0]    wr_data;

    bank_dispatch u_dispatch (
        .clk         (clk),
        .reset       (reset),
        .in_sos      (in_sos),
        .in_eos      (in_eos),
        .in_change   (in_change),
        .in_data     (in_data),
        .in_node_id  (in_node_id),
        .bank_busy   (bank_busy),
        .bank_stream (bank_stream),
        .in_ready    (in_ready)
    );

    for (genvar g = 0; g < num_banks; g++) begin : gen_bank
        vertex_accum_bank u_bank (
            .clk    (clk),
            .reset  (reset),
            .stream (bank_stream[g]),
            .out    (bank_out[g]),
            .busy   (bank_busy[g])
        );
    end

    output_arbiter u_arbiter (
        .clk        (clk),
        .reset      (reset),
        .req_port   (bank_out),
        .wr_en      (wr_en),
        .wr_sos     (wr_sos),
        .wr_node_id (wr_node_id),
        .wr_data    (wr_data)
    );

    output_feature_sram u_sram (
        .clk        (clk),
        .reset      (reset),
        .wr_en      (wr_en),
        .wr_sos     (wr_sos),
        .wr_node_id (wr_node_id),
        .wr_data    (wr_data),
        .rd_en      (rd_en),
        .rd_node    (rd_node),
        .rd_word    (rd_word),
        .rd_data    (rd_data)
    );

endmodule

/* hw/gnn_bank_pkg.sv */
package gnn_bank_pkg;

    localparam int num_banks = 2;
    localparam int bank_idx_width = 1;

    // two features per word, even slot in the low half
    localparam int word_width = 16;
    localparam int words_per_node = 4;
    localparam int word_idx_width = 2;

    // 16 nodes times words_per_node
    localparam int sram_depth = 64;
    localparam int sram_addr_width = 6;

    typedef enum logic [1:0] {
        idle,
        stream_in,
        out_wait,
        out_burst
    } bank_state_t;

endpackage

/* hw/gnn_feature_pkg.sv */
package gnn_feature_pkg;

    // one weighted feature value, sums wrap modulo 256
    localparam int feature_width = 8;

    // feature slots held per destination node
    localparam int max_fv_num = 8;

    // slot counter, one spare bit so it can hold the full count
    localparam int fv_cnt_width = 4;

    // 16 destination nodes
    localparam int node_id_width = 4;

endpackage

/* hw/out_req_if.sv */
`timescale 1ns/1ps

interface out_req_if import gnn_feature_pkg::*, gnn_bank_pkg::*; ();

    logic                     req;
    logic                     grant;
    logic                     grant_valid;
    logic                     sos;
    logic                     eos;
    logic [word_width-1:0]    data;
    logic [node_id_width-1:0] node_id;

    modport bank (
        output req,
        input  grant,
        output grant_valid,
        output sos,
        output eos,
        output data,
        output node_id
    );

    modport arbiter (
        input  req,
        output grant,
        input  grant_valid,
        input  sos,
        input  eos,
        input  data,
        input  node_id
    );

endinterface

/* hw/output_arbiter.sv */
`timescale 1ns/1ps

module output_arbiter import gnn_feature_pkg::*, gnn_bank_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    out_req_if.arbiter               req_port [num_banks],
    output logic                     wr_en,
    output logic                     wr_sos,
    output logic [node_id_width-1:0] wr_node_id,
    output logic [word_width-1:0]    wr_data
);

    logic [num_banks-1:0]     req_vec;
    logic [num_banks-1:0]     gv_vec;
    logic [num_banks-1:0]     sos_vec;
    logic [num_banks-1:0]     eos_vec;
    logic [num_banks-1:0]     grant_vec;
    logic [word_width-1:0]    data_arr [num_banks];
    logic [node_id_width-1:0] node_arr [num_banks];

    // last winner, also the owner while a burst is locked
    logic [bank_idx_width-1:0] last_win;
    logic [bank_idx_width-1:0] winner;
    logic [bank_idx_width-1:0] sel;
    logic                      active;

    for (genvar i = 0; i < num_banks; i++) begin : gen_port
        assign req_vec[i]      = req_port[i].req;
        assign gv_vec[i]       = req_port[i].grant_valid;
        assign sos_vec[i]      = req_port[i].sos;
        assign eos_vec[i]      = req_port[i].eos;
        assign data_arr[i]     = req_port[i].data;
        assign node_arr[i]     = req_port[i].node_id;
        assign req_port[i].grant = grant_vec[i];
    end

    // search starts one past the last winner
    always_comb begin
        int cand;
        winner = last_win;
        for (int k = num_banks; k >= 1; k--) begin
            cand = (int'(last_win) + k) % num_banks;
            if (req_vec[cand]) begin
                winner = bank_idx_width'(cand);
            end
        end
    end

    always_comb begin
        grant_vec = '0;
        if (active) begin
            grant_vec[last_win] = 1'b1;
        end else if (|req_vec) begin
            grant_vec[winner] = 1'b1;
        end
    end

    assign sel        = active ? last_win : winner;
    assign wr_en      = gv_vec[sel];
    assign wr_sos     = sos_vec[sel];
    assign wr_node_id = node_arr[sel];
    assign wr_data    = data_arr[sel];

    always_ff @(posedge clk) begin
        if (reset) begin
            active   <= 1'b0;
            last_win <= bank_idx_width'(num_banks - 1);
        end else if (!active) begin
            // lock only once the bank has taken the grant
            if (gv_vec[sel] && sos_vec[sel]) begin
                last_win <= sel;
                active   <= !eos_vec[sel];
            end
        end else if (gv_vec[last_win] && eos_vec[last_win]) begin
            active <= 1'b0;
        end
    end

endmodule

/* hw/output_feature_sram.sv */
`timescale 1ns/1ps

module output_feature_sram import gnn_feature_pkg::*, gnn_bank_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      wr_en,
    input  logic                      wr_sos,
    input  logic [node_id_width-1:0]  wr_node_id,
    input  logic [word_width-1:0]     wr_data,
    input  logic                      rd_en,
    input  logic [node_id_width-1:0]  rd_node,
    input  logic [word_idx_width-1:0] rd_word,
    output logic [word_width-1:0]     rd_data
);

    logic [word_width-1:0]      mem [sram_depth];
    logic [word_idx_width-1:0]  word_idx;
    logic [word_idx_width-1:0]  cur_idx;
    logic [sram_addr_width-1:0] wr_addr;
    logic [sram_addr_width-1:0] rd_addr;

    // every burst starts at word 0 of its node
    assign cur_idx = wr_sos ? '0 : word_idx;

    assign wr_addr = sram_addr_width'(wr_node_id) * sram_addr_width'(words_per_node)
                   + sram_addr_width'(cur_idx);
    assign rd_addr = sram_addr_width'(rd_node) * sram_addr_width'(words_per_node)
                   + sram_addr_width'(rd_word);

    always_ff @(posedge clk) begin
        if (reset) begin
            word_idx <= '0;
            for (int i = 0; i < sram_depth; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[wr_addr] <= wr_data;
            word_idx     <= cur_idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* hw/vertex_accum_bank.sv */
`timescale 1ns/1ps

module vertex_accum_bank import gnn_feature_pkg::*, gnn_bank_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    vertex_stream_if.bank    stream,
    out_req_if.bank          out,
    output logic             busy
);

    logic [max_fv_num-1:0][feature_width-1:0] slots;
    logic [fv_cnt_width-1:0]                  cnt;
    logic [fv_cnt_width-1:0]                  fv_num;
    logic [node_id_width-1:0]                 cur_node;
    bank_state_t                              state;

    logic [fv_cnt_width-2:0] slot_idx;
    logic [fv_cnt_width-2:0] hi_idx;
    logic [feature_width-1:0] lo_feat;
    logic [feature_width-1:0] hi_feat;
    logic                     last_word;

    assign busy = (state != idle);

    // cnt is even while streaming out, so hi_idx stays in range
    assign slot_idx = cnt[fv_cnt_width-2:0];
    assign hi_idx   = slot_idx + 1'b1;

    assign lo_feat = slots[slot_idx];
    // odd slot past the filled count goes out as zero
    assign hi_feat = (cnt + fv_cnt_width'(1) < fv_num) ? slots[hi_idx] : '0;

    assign last_word = (cnt + fv_cnt_width'(2) >= fv_num);

    always_comb begin
        out.req         = 1'b0;
        out.grant_valid = 1'b0;
        out.sos         = 1'b0;
        out.eos         = 1'b0;
        out.data        = '0;
        out.node_id     = cur_node;
        case (state)
            idle: begin
                // one-beat packet asks for the SRAM right away
                out.req = stream.sos && stream.eos;
            end
            stream_in: begin
                out.req = stream.eos;
            end
            out_wait: begin
                // request held through the grant cycle
                out.req = 1'b1;
                if (out.grant) begin
                    out.grant_valid = 1'b1;
                    out.sos         = 1'b1;
                    out.eos         = last_word;
                    out.data        = {hi_feat, lo_feat};
                end
            end
            out_burst: begin
                out.grant_valid = 1'b1;
                out.eos         = last_word;
                out.data        = {hi_feat, lo_feat};
            end
            default: begin
                out.req = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= idle;
            cnt      <= '0;
            fv_num   <= '0;
            cur_node <= '0;
            slots    <= '0;
        end else begin
            case (state)
                idle: begin
                    if (stream.sos) begin
                        slots[slot_idx] <= slots[slot_idx] + stream.data;
                        cur_node        <= stream.node_id;
                        if (stream.eos) begin
                            state  <= out_wait;
                            fv_num <= fv_cnt_width'(1);
                        end else begin
                            state <= stream_in;
                            if (stream.change) begin
                                cnt <= cnt + fv_cnt_width'(1);
                            end
                        end
                    end
                end
                stream_in: begin
                    slots[slot_idx] <= slots[slot_idx] + stream.data;
                    if (stream.eos) begin
                        state  <= out_wait;
                        fv_num <= cnt + fv_cnt_width'(1);
                        cnt    <= '0;
                    end else if (stream.change) begin
                        cnt <= cnt + fv_cnt_width'(1);
                    end
                end
                out_wait: begin
                    if (out.grant) begin
                        if (last_word) begin
                            state <= idle;
                            slots <= '0;
                            cnt   <= '0;
                        end else begin
                            state <= out_burst;
                            cnt   <= cnt + fv_cnt_width'(2);
                        end
                    end
                end
                out_burst: begin
                    if (last_word) begin
                        state <= idle;
                        slots <= '0;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + fv_cnt_width'(2);
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

/* hw/vertex_stream_if.sv */
`timescale 1ns/1ps

interface vertex_stream_if import gnn_feature_pkg::*; ();

    logic [feature_width-1:0] data;
    logic [node_id_width-1:0] node_id;
    logic                     sos;
    logic                     eos;
    // advance to the next slot after this beat
    logic                     change;

    modport source (
        output data,
        output node_id,
        output sos,
        output eos,
        output change
    );

    modport bank (
        input data,
        input node_id,
        input sos,
        input eos,
        input change
    );

endinterface

/* sources.f */
hw/gnn_feature_pkg.sv
hw/gnn_bank_pkg.sv
hw/vertex_stream_if.sv
hw/out_req_if.sv
hw/vertex_accum_bank.sv
hw/bank_dispatch.sv
hw/output_arbiter.sv
hw/output_feature_sram.sv
hw/gnn_accum_top.sv
testbench/gnn_accum_sva.sv
testbench/tb_gnn_accum.sv

/* testbench/gnn_accum_sva.sv */
`timescale 1ns/1ps

module gnn_accum_sva import gnn_feature_pkg::*, gnn_bank_pkg::*; (
    input logic                                          clk,
    input logic                                          reset,
    input logic                                          in_ready,
    input logic [num_banks-1:0]                          req,
    input logic [num_banks-1:0]                          grant,
    input logic [num_banks-1:0]                          grant_valid,
    input logic [num_banks-1:0]                          word_sos,
    input logic [num_banks-1:0]                          word_eos,
    input logic [num_banks-1:0][$bits(bank_state_t)-1:0] bank_state
);

    for (genvar i = 0; i < num_banks; i++) begin : gen_chk
        // a burst opens only after the bank asked for the SRAM
        a_req_first: assert property (@(posedge clk) disable iff (reset)
            (grant_valid[i] && word_sos[i]) |-> $past(req[i]))
            else $error("bank %0d started a burst without a prior request", i);

        a_contiguous: assert property (@(posedge clk) disable iff (reset)
            (grant_valid[i] && !word_eos[i]) |=> (grant_valid[i] && !word_sos[i]))
            else $error("bank %0d burst has a gap or a restart before eos", i);

        // arbiter stays locked on the bank for its whole burst
        a_burst_grant: assert property (@(posedge clk) disable iff (reset)
            (bank_state_t'(bank_state[i]) == out_burst) |-> grant[i])
            else $error("bank %0d is in a burst without the arbiter's grant", i);
    end

    a_one_writer: assert property (@(posedge clk) disable iff (reset) $onehot0(grant_valid))
        else $error("more than one bank sent a word to the SRAM in one cycle");

    a_ready_after_reset: assert property (@(posedge clk) $fell(reset) |-> in_ready)
        else $error("in_ready low right after reset");

endmodule

bind gnn_accum_top gnn_accum_sva sva_i (
    .clk         (clk),
    .reset       (reset),
    .in_ready    (in_ready),
    .req         ({bank_out[1].req, bank_out[0].req}),
    .grant       ({bank_out[1].grant, bank_out[0].grant}),
    .grant_valid ({bank_out[1].grant_valid, bank_out[0].grant_valid}),
    .word_sos    ({bank_out[1].sos, bank_out[0].sos}),
    .word_eos    ({bank_out[1].eos, bank_out[0].eos}),
    .bank_state  ({gen_bank[1].u_bank.state, gen_bank[0].u_bank.state})
);

/* testbench/tb_gnn_accum.sv */
`timescale 1ns/1ps

module tb_gnn_accum import gnn_feature_pkg::*, gnn_bank_pkg::*;;

    logic                      clk;
    logic                      reset;
    logic                      in_sos;
    logic                      in_eos;
    logic                      in_change;
    logic [feature_width-1:0]  in_data;
    logic [node_id_width-1:0]  in_node_id;
    logic                      in_ready;
    logic                      rd_en;
    logic [node_id_width-1:0]  rd_node;
    logic [word_idx_width-1:0] rd_word;
    logic [word_width-1:0]     rd_data;

    logic [word_width-1:0] model_mem [sram_depth];
    logic [31:0]           lfsr_state;
    int                    checks;
    int                    errors;
    int                    test_errors;
    string                 test_name;

    gnn_accum_top uut (
        .clk        (clk),
        .reset      (reset),
        .in_sos     (in_sos),
        .in_eos     (in_eos),
        .in_change  (in_change),
        .in_data    (in_data),
        .in_node_id (in_node_id),
        .in_ready   (in_ready),
        .rd_en      (rd_en),
        .rd_node    (rd_node),
        .rd_word    (rd_word),
        .rd_data    (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return v;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $finish;
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge clk);
        while (!in_ready) begin
            n++;
            if (n > 200) begin
                fail_run("timed out waiting for in_ready to rise");
            end
            @(negedge clk);
        end
    endtask

    // all banks idle means the last burst is in the SRAM
    task automatic wait_drained();
        int n;
        n = 0;
        @(negedge clk);
        while (uut.bank_busy != '0) begin
            n++;
            if (n > 200) begin
                fail_run("timed out waiting for the banks to finish their bursts");
            end
            @(negedge clk);
        end
    endtask

    // beats == 0 picks 1 to 3 beats per slot at random
    task automatic send_packet(input logic [node_id_width-1:0] node, input int n_slots,
                               input int beats, input bit big);
        logic [feature_width-1:0] sums [max_fv_num];
        logic [feature_width-1:0] val;
        logic [feature_width-1:0] hi;
        int nb;
        for (int s = 0; s < max_fv_num; s++) begin
            sums[s] = '0;
        end
        wait_ready();
        for (int s = 0; s < n_slots; s++) begin
            nb = (beats > 0) ? beats : 1 + int'(rand_bits(2)) % 3;
            for (int b = 0; b < nb; b++) begin
                val = feature_width'(rand_bits(feature_width));
                if (big) begin
                    val = val | 8'hc0;
                end
                sums[s] = sums[s] + val;
                @(posedge clk);
                in_sos     <= (s == 0) && (b == 0);
                in_eos     <= (s == n_slots - 1) && (b == nb - 1);
                in_change  <= (b == nb - 1) && (s != n_slots - 1);
                in_data    <= val;
                in_node_id <= node;
            end
        end
        @(posedge clk);
        in_sos    <= 1'b0;
        in_eos    <= 1'b0;
        in_change <= 1'b0;
        in_data   <= '0;
        // even slot low, odd slot high, missing odd slot is zero
        for (int w = 0; w < (n_slots + 1) / 2; w++) begin
            hi = (2 * w + 1 < n_slots) ? sums[2 * w + 1] : '0;
            model_mem[int'(node) * words_per_node + w] = {hi, sums[2 * w]};
        end
    endtask

    task automatic check_node(input logic [node_id_width-1:0] node);
        logic [word_width-1:0] exp;
        for (int w = 0; w < words_per_node; w++) begin
            exp = model_mem[int'(node) * words_per_node + w];
            @(posedge clk);
            rd_en   <= 1'b1;
            rd_node <= node;
            rd_word <= word_idx_width'(w);
            @(posedge clk);
            @(negedge clk);
            checks++;
            assert (rd_data === exp) else begin
                errors++;
                test_errors++;
                $display("Mismatch %s node %0d word %0d: expected %h actual %h",
                         test_name, node, w, exp, rd_data);
            end
        end
        @(posedge clk);
        rd_en <= 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        $display("test %s finished with %0d errors", test_name, test_errors);
    endtask

    initial begin
        lfsr_state = 32'h12f9;
        checks     = 0;
        errors     = 0;
        for (int i = 0; i < sram_depth; i++) begin
            model_mem[i] = '0;
        end
        reset      = 1'b1;
        in_sos     = 1'b0;
        in_eos     = 1'b0;
        in_change  = 1'b0;
        in_data    = '0;
        in_node_id = '0;
        rd_en      = 1'b0;
        rd_node    = '0;
        rd_word    = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        start_test("after_reset");
        @(negedge clk);
        checks++;
        assert (in_ready) else begin
            errors++;
            test_errors++;
            $display("%s: in_ready was low after reset", test_name);
        end
        check_node(5);
        end_test();

        start_test("one_beat");
        send_packet(3, 1, 1, 1'b0);
        wait_drained();
        check_node(3);
        end_test();

        start_test("multi_beat");
        for (int n = 1; n <= max_fv_num; n++) begin
            send_packet(node_id_width'(n + 5), n, 0, 1'b0);
            wait_drained();
            check_node(node_id_width'(n + 5));
        end
        end_test();

        start_test("two_banks");
        send_packet(0, 5, 0, 1'b0);
        send_packet(1, 6, 0, 1'b0);
        wait_drained();
        check_node(0);
        check_node(1);
        end_test();

        // long packet then a one-beat packet fills both banks
        start_test("all_busy");
        send_packet(14, 8, 1, 1'b0);
        send_packet(15, 1, 1, 1'b0);
        @(negedge clk);
        checks++;
        assert (!in_ready) else begin
            errors++;
            test_errors++;
            $display("%s: in_ready stayed high with both banks busy", test_name);
        end
        send_packet(4, 3, 0, 1'b0);
        wait_drained();
        check_node(14);
        check_node(15);
        check_node(4);
        end_test();

        start_test("wrap_repeat");
        send_packet(2, 6, 3, 1'b1);
        wait_drained();
        check_node(2);
        send_packet(2, 2, 2, 1'b1);
        wait_drained();
        check_node(2);
        end_test();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
